//--- Bender.yml
package:
  name: peri_subsys

sources:
  - hw/peri_pkg.sv
  - hw/wb_peri_decode.sv
  - hw/peri_event_flag.sv
  - hw/peri_i2c_master.sv
  - hw/peri_led.sv
  - hw/peri_top.sv
  - target: test
    files:
      - tests/peri_chk.sv
      - tests/peri_tb.sv

//--- hw/peri_event_flag.sv
`timescale 1ns/1ps

module peri_event_flag #(
    parameter int FLAG_WIDTH = 32
) (
    input  logic                  wb_peri_clk_i,
    input  logic                  wb_peri_rst_i,

    input  peri_pkg::wb_req_t     wb_req_i,
    input  logic                  stb_i,
    output peri_pkg::wb_rsp_t     wb_rsp_o,

    input  logic [FLAG_WIDTH-1:0] set_flg_i,
    output logic                  irq_o
);

    logic [FLAG_WIDTH-1:0]             flg_ptn;
    logic [FLAG_WIDTH-1:0]             flg_ena;
    logic [FLAG_WIDTH-1:0]             clr_mask;
    logic [peri_pkg::WB_DAT_WIDTH-1:0] byte_mask;
    logic                              wr_ptn;
    logic                              wr_ena;

    // Expand byte selects to a bit mask
    always_comb begin
        for (int i = 0; i < peri_pkg::WB_DAT_WIDTH; i++) begin
            byte_mask[i] = wb_req_i.sel[i/8];
        end
    end

    assign wr_ptn = stb_i && wb_req_i.we && (wb_req_i.adr[1:0] == peri_pkg::FLG_REG_PTN);
    assign wr_ena = stb_i && wb_req_i.we && (wb_req_i.adr[1:0] == peri_pkg::FLG_REG_ENA);

    // Write-one-to-clear on the pattern
    assign clr_mask = wr_ptn ? (wb_req_i.dat[FLAG_WIDTH-1:0] & byte_mask[FLAG_WIDTH-1:0]) : '0;

    always_ff @(posedge wb_peri_clk_i) begin
        if (wb_peri_rst_i) begin
            flg_ptn <= '0;
            flg_ena <= '0;
        end else begin
            // A set in the same cycle wins over the clear
            flg_ptn <= (flg_ptn & ~clr_mask) | set_flg_i;
            if (wr_ena) begin
                flg_ena <= (flg_ena & ~byte_mask[FLAG_WIDTH-1:0])
                         | (wb_req_i.dat[FLAG_WIDTH-1:0] & byte_mask[FLAG_WIDTH-1:0]);
            end
        end
    end

    assign irq_o = |(flg_ptn & flg_ena);

    always_comb begin
        wb_rsp_o.ack = stb_i;
        case (wb_req_i.adr[1:0])
            peri_pkg::FLG_REG_PTN: wb_rsp_o.dat = peri_pkg::WB_DAT_WIDTH'(flg_ptn);
            peri_pkg::FLG_REG_ENA: wb_rsp_o.dat = peri_pkg::WB_DAT_WIDTH'(flg_ena);
            default:               wb_rsp_o.dat = '0;
        endcase
    end

endmodule

//--- hw/peri_i2c_master.sv
`timescale 1ns/1ps

module peri_i2c_master #(
    parameter int DIVIDER_WIDTH = 16,
    parameter int DIVIDER_INIT  = 2000
) (
    input  logic              wb_peri_clk_i,
    input  logic              wb_peri_rst_i,

    input  peri_pkg::wb_req_t wb_req_i,
    input  logic              stb_i,
    output peri_pkg::wb_rsp_t wb_rsp_o,

    output logic              scl_t_o,
    input  logic              scl_i,
    output logic              sda_t_o,
    input  logic              sda_i,

    output logic              done_o
);

    typedef enum logic [1:0] {ST_IDLE, ST_START, ST_BIT, ST_STOP} state_t;

    state_t                            state;
    state_t                            nxt_state;
    logic [1:0]                        ph;
    logic [1:0]                        nxt_ph;
    logic [3:0]                        bit_cnt;
    logic [3:0]                        nxt_bit_cnt;
    logic [DIVIDER_WIDTH-1:0]          cnt;
    logic [DIVIDER_WIDTH-1:0]          div_reg;
    logic [7:0]                        shift;
    logic                              rd;
    logic                              stop;
    logic                              nack;
    logic                              tx_msb;
    logic                              tx_rd;
    logic                              tx_stop;
    logic                              busy;
    logic                              launch;
    logic                              stretch;
    logic                              tick;
    logic                              finish;
    logic                              scl_nxt;
    logic                              sda_nxt;
    logic                              wr_div;
    logic [peri_pkg::WB_DAT_WIDTH-1:0] byte_mask;

    always_comb begin
        for (int i = 0; i < peri_pkg::WB_DAT_WIDTH; i++) begin
            byte_mask[i] = wb_req_i.sel[i/8];
        end
    end

    assign busy   = (state != ST_IDLE);
    assign wr_div = stb_i && wb_req_i.we && (wb_req_i.adr[1:0] == peri_pkg::I2C_REG_DIV);
    // Command needs both low bytes, ignored while busy
    assign launch = stb_i && wb_req_i.we && (wb_req_i.adr[1:0] == peri_pkg::I2C_REG_CMD)
                    && (&wb_req_i.sel[1:0]) && !busy;

    // Clock stretching, hold the high phase until the slave lets SCL go
    assign stretch = busy && (ph == 2'd1) && !scl_i;
    assign tick    = busy && (cnt == '0) && !stretch;
    assign finish  = tick && (ph == 2'd3)
                     && ((state == ST_STOP) || (state == ST_BIT && bit_cnt == 4'd8 && !stop));

    // ------------------------------------------------------------------
    // Sequencer, next phase and line enables for that phase
    // ------------------------------------------------------------------
    always_comb begin
        nxt_state   = state;
        nxt_ph      = ph;
        nxt_bit_cnt = bit_cnt;
        tx_msb      = shift[7];
        tx_rd       = rd;
        tx_stop     = stop;
        if (launch) begin
            nxt_state   = wb_req_i.dat[8] ? ST_START : ST_BIT;
            nxt_ph      = 2'd0;
            nxt_bit_cnt = 4'd0;
            tx_msb      = wb_req_i.dat[7];
            tx_rd       = wb_req_i.dat[10];
            tx_stop     = wb_req_i.dat[9];
        end else if (tick) begin
            nxt_ph = ph + 2'd1;
            if (ph == 2'd3) begin
                case (state)
                    ST_START: nxt_state = ST_BIT;
                    ST_BIT: begin
                        if (bit_cnt != 4'd8) begin
                            nxt_bit_cnt = bit_cnt + 4'd1;
                        end else begin
                            nxt_state = stop ? ST_STOP : ST_IDLE;
                        end
                    end
                    default: nxt_state = ST_IDLE;
                endcase
            end
        end
    end

    always_comb begin
        scl_nxt = scl_t_o;
        sda_nxt = sda_t_o;
        if (launch || tick) begin
            case (nxt_state)
                ST_START: begin
                    case (nxt_ph)
                        2'd0: sda_nxt = 1'b0;
                        2'd1: scl_nxt = 1'b0;
                        2'd2: sda_nxt = 1'b1;
                        default: scl_nxt = 1'b1;
                    endcase
                end
                ST_BIT: begin
                    scl_nxt = (nxt_ph == 2'd0) || (nxt_ph == 2'd3);
                    if (nxt_ph == 2'd0) begin
                        // Ack slot: drive ack on reads unless a stop follows
                        sda_nxt = (nxt_bit_cnt == 4'd8) ? (tx_rd && !tx_stop)
                                                        : (!tx_rd && !tx_msb);
                    end
                end
                ST_STOP: begin
                    case (nxt_ph)
                        2'd0: begin
                            scl_nxt = 1'b1;
                            sda_nxt = 1'b1;
                        end
                        2'd1: scl_nxt = 1'b0;
                        2'd2: sda_nxt = 1'b0;
                        default: sda_nxt = 1'b0;
                    endcase
                end
                default: scl_nxt = scl_t_o;
            endcase
        end
    end

    always_ff @(posedge wb_peri_clk_i) begin
        if (wb_peri_rst_i) begin
            state   <= ST_IDLE;
            ph      <= 2'd0;
            bit_cnt <= 4'd0;
            cnt     <= '0;
            div_reg <= DIVIDER_WIDTH'(DIVIDER_INIT);
            rd      <= 1'b0;
            stop    <= 1'b0;
            nack    <= 1'b0;
            scl_t_o <= 1'b0;
            sda_t_o <= 1'b0;
            done_o  <= 1'b0;
        end else begin
            state   <= nxt_state;
            ph      <= nxt_ph;
            bit_cnt <= nxt_bit_cnt;
            rd      <= tx_rd;
            stop    <= tx_stop;
            scl_t_o <= scl_nxt;
            sda_t_o <= sda_nxt;
            done_o  <= finish;
            if (launch || tick || stretch) begin
                cnt <= div_reg;
            end else if (busy) begin
                cnt <= cnt - 1'b1;
            end
            if (wr_div) begin
                div_reg <= (div_reg & ~byte_mask[DIVIDER_WIDTH-1:0])
                         | (wb_req_i.dat[DIVIDER_WIDTH-1:0] & byte_mask[DIVIDER_WIDTH-1:0]);
            end
            if (launch) begin
                nack <= 1'b0;
            end else if (tick && state == ST_BIT && ph == 2'd2 && bit_cnt == 4'd8) begin
                nack <= !rd && sda_i;
            end
        end
    end

    // Sample at the end of the SCL high phase
    always_ff @(posedge wb_peri_clk_i) begin
        if (launch) begin
            shift <= wb_req_i.dat[7:0];
        end else if (tick && state == ST_BIT && ph == 2'd2 && bit_cnt != 4'd8) begin
            shift <= {shift[6:0], sda_i};
        end
    end

    always_comb begin
        wb_rsp_o.ack = stb_i;
        case (wb_req_i.adr[1:0])
            peri_pkg::I2C_REG_STATUS: wb_rsp_o.dat = peri_pkg::WB_DAT_WIDTH'({nack, busy});
            peri_pkg::I2C_REG_RXDATA: wb_rsp_o.dat = peri_pkg::WB_DAT_WIDTH'(shift);
            peri_pkg::I2C_REG_DIV:    wb_rsp_o.dat = peri_pkg::WB_DAT_WIDTH'(div_reg);
            default:                  wb_rsp_o.dat = '0;
        endcase
    end

endmodule

//--- hw/peri_led.sv
`timescale 1ns/1ps

module peri_led #(
    parameter int COUNT_WIDTH = 26
) (
    input  logic              wb_peri_clk_i,
    input  logic              wb_peri_rst_i,

    input  peri_pkg::wb_req_t wb_req_i,
    input  logic              stb_i,
    output peri_pkg::wb_rsp_t wb_rsp_o,

    output logic [1:0]        led_o
);

    logic                   led_bit;
    logic [COUNT_WIDTH-1:0] clk_count;
    logic                   sel_ctrl;

    assign sel_ctrl = (wb_req_i.adr[1:0] == peri_pkg::LED_REG_CTRL);

    always_ff @(posedge wb_peri_clk_i) begin
        if (wb_peri_rst_i) begin
            led_bit   <= 1'b0;
            clk_count <= '0;
        end else begin
            clk_count <= clk_count + 1'b1;
            if (stb_i && wb_req_i.we && wb_req_i.sel[0] && sel_ctrl) begin
                led_bit <= wb_req_i.dat[0];
            end
        end
    end

    // Heartbeat from the counter MSB
    assign led_o = {clk_count[COUNT_WIDTH-1], led_bit};

    assign wb_rsp_o.ack = stb_i;
    assign wb_rsp_o.dat = sel_ctrl ? peri_pkg::WB_DAT_WIDTH'(led_bit) : '0;

endmodule

//--- hw/peri_pkg.sv
package peri_pkg;

    // ------------------------------------------------------------------
    // Bus widths
    // ------------------------------------------------------------------
    localparam int WB_ADR_WIDTH = 24;
    localparam int WB_DAT_WIDTH = 32;
    localparam int WB_SEL_WIDTH = 4;

    typedef struct packed {
        logic [WB_ADR_WIDTH-1:0] adr;
        logic [WB_DAT_WIDTH-1:0] dat;
        logic                    we;
        logic [WB_SEL_WIDTH-1:0] sel;
        logic                    stb;
    } wb_req_t;

    typedef struct packed {
        logic [WB_DAT_WIDTH-1:0] dat;
        logic                    ack;
    } wb_rsp_t;

    // ------------------------------------------------------------------
    // Address map, block number in adr[23:16]
    // ------------------------------------------------------------------
    localparam logic [7:0] BLK_FLAG = 8'd0;
    localparam logic [7:0] BLK_I2C  = 8'd1;
    localparam logic [7:0] BLK_LED  = 8'd2;

    // Register offsets in adr[1:0]
    localparam logic [1:0] FLG_REG_PTN    = 2'd0;
    localparam logic [1:0] FLG_REG_ENA    = 2'd1;
    localparam logic [1:0] I2C_REG_STATUS = 2'd0;
    localparam logic [1:0] I2C_REG_CMD    = 2'd1;
    localparam logic [1:0] I2C_REG_RXDATA = 2'd2;
    localparam logic [1:0] I2C_REG_DIV    = 2'd3;
    localparam logic [1:0] LED_REG_CTRL   = 2'd0;

endpackage

//--- hw/peri_top.sv
`timescale 1ns/1ps

module peri_top #(
    parameter int COUNT_WIDTH  = 26,
    parameter int DIVIDER_INIT = 2000,
    parameter int FLAG_WIDTH   = 32
) (
    input  logic              wb_peri_clk_i,
    input  logic              wb_peri_rst_i,

    input  peri_pkg::wb_req_t wb_req_i,
    output peri_pkg::wb_rsp_t wb_rsp_o,

    output logic              i2c_scl_t_o,
    input  logic              i2c_scl_i,
    output logic              i2c_sda_t_o,
    input  logic              i2c_sda_i,

    output logic [1:0]        led_o,
    output logic              irq_o
);

    logic              flag_stb;
    logic              i2c_stb;
    logic              led_stb;
    peri_pkg::wb_rsp_t flag_rsp;
    peri_pkg::wb_rsp_t i2c_rsp;
    peri_pkg::wb_rsp_t led_rsp;
    logic              i2c_done;

    wb_peri_decode u_decode (
        .wb_req_i   (wb_req_i),
        .wb_rsp_o   (wb_rsp_o),
        .flag_stb_o (flag_stb),
        .i2c_stb_o  (i2c_stb),
        .led_stb_o  (led_stb),
        .flag_rsp_i (flag_rsp),
        .i2c_rsp_i  (i2c_rsp),
        .led_rsp_i  (led_rsp)
    );

    // I2C completion lands on flag bit 0
    peri_event_flag #(.FLAG_WIDTH(FLAG_WIDTH)) u_flag (
        .wb_peri_clk_i (wb_peri_clk_i),
        .wb_peri_rst_i (wb_peri_rst_i),
        .wb_req_i      (wb_req_i),
        .stb_i         (flag_stb),
        .wb_rsp_o      (flag_rsp),
        .set_flg_i     (FLAG_WIDTH'(i2c_done)),
        .irq_o         (irq_o)
    );

    peri_i2c_master #(.DIVIDER_INIT(DIVIDER_INIT)) u_i2c (
        .wb_peri_clk_i (wb_peri_clk_i),
        .wb_peri_rst_i (wb_peri_rst_i),
        .wb_req_i      (wb_req_i),
        .stb_i         (i2c_stb),
        .wb_rsp_o      (i2c_rsp),
        .scl_t_o       (i2c_scl_t_o),
        .scl_i         (i2c_scl_i),
        .sda_t_o       (i2c_sda_t_o),
        .sda_i         (i2c_sda_i),
        .done_o        (i2c_done)
    );

    peri_led #(.COUNT_WIDTH(COUNT_WIDTH)) u_led (
        .wb_peri_clk_i (wb_peri_clk_i),
        .wb_peri_rst_i (wb_peri_rst_i),
        .wb_req_i      (wb_req_i),
        .stb_i         (led_stb),
        .wb_rsp_o      (led_rsp),
        .led_o         (led_o)
    );

endmodule

//--- hw/wb_peri_decode.sv
`timescale 1ns/1ps

module wb_peri_decode (
    input  peri_pkg::wb_req_t wb_req_i,
    output peri_pkg::wb_rsp_t wb_rsp_o,

    output logic              flag_stb_o,
    output logic              i2c_stb_o,
    output logic              led_stb_o,

    input  peri_pkg::wb_rsp_t flag_rsp_i,
    input  peri_pkg::wb_rsp_t i2c_rsp_i,
    input  peri_pkg::wb_rsp_t led_rsp_i
);

    logic [7:0] blk;

    // Block number sits in the top byte of the word address
    assign blk = wb_req_i.adr[peri_pkg::WB_ADR_WIDTH-1:16];

    assign flag_stb_o = wb_req_i.stb && (blk == peri_pkg::BLK_FLAG);
    assign i2c_stb_o  = wb_req_i.stb && (blk == peri_pkg::BLK_I2C);
    assign led_stb_o  = wb_req_i.stb && (blk == peri_pkg::BLK_LED);

    // ------------------------------------------------------------------
    // Return mux
    // ------------------------------------------------------------------
    always_comb begin
        wb_rsp_o = '0;
        if (flag_stb_o) begin
            wb_rsp_o = flag_rsp_i;
        end else if (i2c_stb_o) begin
            wb_rsp_o = i2c_rsp_i;
        end else if (led_stb_o) begin
            wb_rsp_o = led_rsp_i;
        end else begin
            // Unmapped block, ack with zero data so the master never hangs
            wb_rsp_o.ack = wb_req_i.stb;
        end
    end

endmodule

//--- list.f
hw/peri_pkg.sv
hw/wb_peri_decode.sv
hw/peri_event_flag.sv
hw/peri_i2c_master.sv
hw/peri_led.sv
hw/peri_top.sv
tests/peri_chk.sv
tests/peri_tb.sv

//--- tests/peri_chk.sv
`timescale 1ns/1ps

module peri_chk (
    input logic       wb_peri_clk_i,
    input logic       wb_peri_rst_i,
    input logic       stb_i,
    input logic       ack_i,
    input logic       irq_i,
    input logic [1:0] led_i,
    input logic       scl_t_i,
    input logic       sda_t_i,
    input logic       scl_i,
    input logic       sda_i
);

    assert property (@(posedge wb_peri_clk_i) ack_i |-> stb_i)
        else $error("Wishbone ack seen without a strobe");

    assert property (@(posedge wb_peri_clk_i) disable iff (wb_peri_rst_i)
        !$isunknown({irq_i, led_i, scl_t_i, sda_t_i}))
        else $error("Unknown value on irq, led or I2C line enables");

    // Under a high SCL, SDA falls only when the master starts and rises only when it stops
    assert property (@(posedge wb_peri_clk_i) disable iff (wb_peri_rst_i)
        (scl_i && $past(scl_i) && $changed(sda_i))
        |-> ((!sda_i && $rose(sda_t_i)) || (sda_i && $fell(sda_t_i))))
        else $error("SDA changed while SCL high outside a start or stop");

endmodule

bind peri_top peri_chk u_chk (
    .wb_peri_clk_i (wb_peri_clk_i),
    .wb_peri_rst_i (wb_peri_rst_i),
    .stb_i         (wb_req_i.stb),
    .ack_i         (wb_rsp_o.ack),
    .irq_i         (irq_o),
    .led_i         (led_o),
    .scl_t_i       (i2c_scl_t_o),
    .sda_t_i       (i2c_sda_t_o),
    .scl_i         (i2c_scl_i),
    .sda_i         (i2c_sda_i)
);

//--- tests/peri_tb.sv
`timescale 1ns/1ps

module peri_tb;

    localparam int          CLK_PERIOD      = 100;
    localparam int          DIV_INIT        = 3;
    localparam int          DIV_TEST        = 5;
    localparam int          NUM_TESTS       = 6;
    // Start, nine bit slots and stop, four phases each
    localparam int          CMD_CYCLES      = 11 * 4 * (DIV_TEST + 1);
    localparam int          WATCHDOG_CYCLES = NUM_TESTS * CMD_CYCLES + 2000;
    localparam int          POLL_LIMIT      = 400;
    localparam logic [15:0] LFSR_SEED       = 16'd34692;
    localparam logic [10:0] CMD_START       = 11'h100;
    localparam logic [10:0] CMD_STOP        = 11'h200;
    localparam logic [10:0] CMD_READ        = 11'h400;

    logic              wb_peri_clk;
    logic              wb_peri_rst;
    peri_pkg::wb_req_t wb_req;
    peri_pkg::wb_rsp_t wb_rsp;
    logic              scl_t;
    logic              sda_t;
    wire               scl_line;
    wire               sda_line;
    logic [1:0]        led;
    logic              irq;

    int                check_count;
    int                error_count;
    int                hb_cycles;
    logic [15:0]       lfsr;

    // I2C slave model
    logic              slv_pull;
    logic              slv_active;
    logic              slv_read;
    logic              ack_en;
    logic [7:0]        slv_rx;
    logic [7:0]        slv_tx;
    int                slv_bits;
    int                starts;
    int                stops;
    int                scl_pulses;

    peri_top #(
        .COUNT_WIDTH  (4),
        .DIVIDER_INIT (DIV_INIT),
        .FLAG_WIDTH   (8)
    ) dut0 (
        .wb_peri_clk_i (wb_peri_clk),
        .wb_peri_rst_i (wb_peri_rst),
        .wb_req_i      (wb_req),
        .wb_rsp_o      (wb_rsp),
        .i2c_scl_t_o   (scl_t),
        .i2c_scl_i     (scl_line),
        .i2c_sda_t_o   (sda_t),
        .i2c_sda_i     (sda_line),
        .led_o         (led),
        .irq_o         (irq)
    );

    // Pull-up ANDed with every open-drain driver
    assign scl_line = 1'b1 & !scl_t;
    assign sda_line = 1'b1 & !sda_t & !slv_pull;

    always #(CLK_PERIOD / 2) wb_peri_clk = ~wb_peri_clk;

    always @(posedge wb_peri_clk) begin
        if (wb_peri_rst) begin
            hb_cycles <= 0;
        end else begin
            hb_cycles <= hb_cycles + 1;
        end
    end

    // ------------------------------------------------------------------
    // I2C slave model
    // ------------------------------------------------------------------
    always @(negedge sda_line) begin
        if (scl_line === 1'b1) begin
            slv_active = 1'b1;
            slv_bits   = 0;
            starts++;
        end
    end

    always @(posedge sda_line) begin
        if (scl_line === 1'b1 && slv_active) begin
            slv_active = 1'b0;
            stops++;
        end
    end

    always @(posedge scl_line) begin
        if (slv_active) begin
            if (slv_bits < 8) begin
                slv_rx = {slv_rx[6:0], sda_line};
            end
            slv_bits++;
        end
    end

    // Set up the next slot while SCL is low
    always @(negedge scl_line) begin
        if (slv_active) begin
            if (slv_bits > 0) begin
                scl_pulses++;
            end
            slv_pull = 1'b0;
            if (slv_bits < 8 && slv_read) begin
                slv_pull = !slv_tx[7 - slv_bits];
            end else if (slv_bits == 8 && !slv_read) begin
                slv_pull = ack_en;
            end
        end
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [23:0] reg_adr(input logic [7:0] blk, input logic [1:0] off);
        return {blk, 14'd0, off};
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic wb_write(input logic [23:0] adr, input logic [31:0] dat, input logic [3:0] sel);
        @(posedge wb_peri_clk);
        #1;
        wb_req.adr = adr;
        wb_req.dat = dat;
        wb_req.sel = sel;
        wb_req.we  = 1'b1;
        wb_req.stb = 1'b1;
        @(negedge wb_peri_clk);
        check_eq("wb_rsp_o.ack", wb_rsp.ack, 1);
        @(posedge wb_peri_clk);
        #1;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
    endtask

    task automatic wb_read(input logic [23:0] adr, output logic [31:0] dat);
        @(posedge wb_peri_clk);
        #1;
        wb_req.adr = adr;
        wb_req.sel = 4'hF;
        wb_req.we  = 1'b0;
        wb_req.stb = 1'b1;
        @(negedge wb_peri_clk);
        check_eq("wb_rsp_o.ack", wb_rsp.ack, 1);
        dat = wb_rsp.dat;
        @(posedge wb_peri_clk);
        #1;
        wb_req.stb = 1'b0;
    endtask

    task automatic run_i2c_cmd(input logic [10:0] cmd, output logic [31:0] status);
        int polls;
        starts     = 0;
        stops      = 0;
        scl_pulses = 0;
        wb_write(reg_adr(peri_pkg::BLK_I2C, peri_pkg::I2C_REG_CMD), {21'd0, cmd}, 4'hF);
        wb_read(reg_adr(peri_pkg::BLK_I2C, peri_pkg::I2C_REG_STATUS), status);
        check_eq("i2c status.busy", status[0], 1);
        polls = 0;
        while (status[0] && polls < POLL_LIMIT) begin
            wb_read(reg_adr(peri_pkg::BLK_I2C, peri_pkg::I2C_REG_STATUS), status);
            polls++;
        end
        if (status[0]) begin
            error_count++;
            $display("ERROR: I2C command still busy after %0d status reads", polls);
        end
    endtask

    task automatic led_register();
        logic [31:0] rdat;
        wb_write(reg_adr(peri_pkg::BLK_LED, peri_pkg::LED_REG_CTRL), 32'h1, 4'hF);
        check_eq("led_o[0]", led[0], 1);
        wb_read(reg_adr(peri_pkg::BLK_LED, peri_pkg::LED_REG_CTRL), rdat);
        check_eq("led ctrl", rdat, 1);
        wb_write(reg_adr(peri_pkg::BLK_LED, peri_pkg::LED_REG_CTRL), 32'h0, 4'hF);
        check_eq("led_o[0]", led[0], 0);
        // Byte 0 not selected
        wb_write(reg_adr(peri_pkg::BLK_LED, peri_pkg::LED_REG_CTRL), 32'hFFFF_FFFF, 4'hE);
        check_eq("led_o[0]", led[0], 0);
        wb_read(reg_adr(peri_pkg::BLK_LED, peri_pkg::LED_REG_CTRL), rdat);
        check_eq("led ctrl", rdat, 0);
    endtask

    task automatic heartbeat();
        repeat (24) begin
            @(posedge wb_peri_clk);
            #1;
            check_eq("led_o[1]", led[1], hb_cycles[3]);
        end
    endtask

    task automatic unmapped_access();
        logic [31:0] rdat;
        wb_read(reg_adr(8'd5, 2'd0), rdat);
        check_eq("unmapped read data", rdat, 0);
        wb_write(reg_adr(8'd5, 2'd0), 32'hFFFF_FFFF, 4'hF);
        wb_write(reg_adr(8'd5, 2'd1), 32'hFFFF_FFFF, 4'hF);
        wb_write(reg_adr(8'd5, 2'd3), 32'hFFFF_FFFF, 4'hF);
        wb_read(reg_adr(peri_pkg::BLK_LED, peri_pkg::LED_REG_CTRL), rdat);
        check_eq("led ctrl", rdat, 0);
        wb_read(reg_adr(peri_pkg::BLK_FLAG, peri_pkg::FLG_REG_ENA), rdat);
        check_eq("flag enable", rdat, 0);
        wb_read(reg_adr(peri_pkg::BLK_I2C, peri_pkg::I2C_REG_DIV), rdat);
        check_eq("i2c divider", rdat, DIV_INIT);
    endtask

    task automatic i2c_write_byte();
        logic [31:0] rdat;
        wb_write(reg_adr(peri_pkg::BLK_I2C, peri_pkg::I2C_REG_DIV), DIV_TEST, 4'hF);
        wb_read(reg_adr(peri_pkg::BLK_I2C, peri_pkg::I2C_REG_DIV), rdat);
        check_eq("i2c divider", rdat, DIV_TEST);
        ack_en   = 1'b1;
        slv_read = 1'b0;
        run_i2c_cmd(CMD_START | CMD_STOP | 11'h0A5, rdat);
        check_eq("i2c status", rdat, 0);
        check_eq("model start count", starts, 1);
        check_eq("model scl pulses", scl_pulses, 9);
        check_eq("model stop count", stops, 1);
        check_eq("model rx byte", slv_rx, 8'hA5);
        // Slave withholds its acknowledge
        ack_en = 1'b0;
        run_i2c_cmd(CMD_START | CMD_STOP | 11'h03C, rdat);
        check_eq("i2c status.nack", rdat[1], 1);
        check_eq("model rx byte", slv_rx, 8'h3C);
        ack_en = 1'b1;
    endtask

    task automatic i2c_read_byte();
        logic [31:0] rdat;
        for (int i = 0; i < 8; i++) begin
            lfsr   = lfsr_next(lfsr);
            slv_tx = {slv_tx[6:0], lfsr[0]};
        end
        slv_read = 1'b1;
        run_i2c_cmd(CMD_START | CMD_STOP | CMD_READ, rdat);
        slv_read = 1'b0;
        check_eq("i2c status", rdat, 0);
        check_eq("model scl pulses", scl_pulses, 9);
        wb_read(reg_adr(peri_pkg::BLK_I2C, peri_pkg::I2C_REG_RXDATA), rdat);
        check_eq("i2c rxdata", rdat, {24'd0, slv_tx});
    endtask

    task automatic event_flags();
        logic [31:0] rdat;
        wb_write(reg_adr(peri_pkg::BLK_FLAG, peri_pkg::FLG_REG_PTN), 32'hFF, 4'hF);
        wb_read(reg_adr(peri_pkg::BLK_FLAG, peri_pkg::FLG_REG_PTN), rdat);
        check_eq("flag pattern", rdat, 0);
        run_i2c_cmd(CMD_START | CMD_STOP | 11'h05A, rdat);
        wb_read(reg_adr(peri_pkg::BLK_FLAG, peri_pkg::FLG_REG_PTN), rdat);
        check_eq("flag pattern", rdat, 1);
        check_eq("irq_o", irq, 0);
        wb_write(reg_adr(peri_pkg::BLK_FLAG, peri_pkg::FLG_REG_ENA), 32'h1, 4'hF);
        check_eq("irq_o", irq, 1);
        wb_write(reg_adr(peri_pkg::BLK_FLAG, peri_pkg::FLG_REG_PTN), 32'h1, 4'hF);
        check_eq("irq_o", irq, 0);
        wb_read(reg_adr(peri_pkg::BLK_FLAG, peri_pkg::FLG_REG_PTN), rdat);
        check_eq("flag pattern", rdat, 0);
    endtask

    initial begin
        wb_peri_clk = 1'b0;
        wb_peri_rst = 1'b1;
        wb_req      = '0;
        check_count = 0;
        error_count = 0;
        lfsr        = LFSR_SEED;
        slv_pull    = 1'b0;
        slv_active  = 1'b0;
        slv_read    = 1'b0;
        ack_en      = 1'b1;
        slv_rx      = '0;
        slv_tx      = '0;
        slv_bits    = 0;
        starts      = 0;
        stops       = 0;
        scl_pulses  = 0;
        repeat (4) @(posedge wb_peri_clk);
        #1;
        wb_peri_rst = 1'b0;
        led_register();
        heartbeat();
        unmapped_access();
        i2c_write_byte();
        i2c_read_byte();
        event_flags();
        $display("Summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("ERROR: run timed out after %0d cycles with %0d errors so far",
                 WATCHDOG_CYCLES, error_count);
        $display("Done: errors found");
        $finish;
    end

endmodule
